/* sdPcmConverter.f */
+incdir+sim
common/sdPcmPkg.sv
coef/coefRegBank.sv
logic/windowDelay.sv
logic/bitWindowLut.sv
logic/cplxRecursion.sv
section/filterSection.sv
logic/sectionCombiner.sv
logic/sdPcmConverter.sv
sim/sdPcmConverterTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the testbench; a $fatal in the run gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module sdPcmConverterTb \
    -f sdPcmConverter.f -o simv &&
./obj_dir/simv || { echo "Simulation run failed"; exit 1; }

/* sim/sdPcmRefModel.svh */
`ifndef SD_PCM_REF_MODEL_SVH
`define SD_PCM_REF_MODEL_SVH

localparam int pcmMax = (1 << (sdPcmPkg::outWidth - 1)) - 1;

// Coefficients as written to the DUT, also read by the model
sdPcmPkg::cplxT cFactor [numSections][sampleWidth];
sdPcmPkg::cplxT cFeedback [numSections];
sdPcmPkg::cplxT cWeight [numSections];

logic [sampleWidth-1:0] mLine [depth];
sdPcmPkg::cplxT mLutNew [numSections];
sdPcmPkg::cplxT mLutOld [numSections];
sdPcmPkg::cplxT mY [numSections];
sdPcmPkg::sampleT mPart [numSections];
sdPcmPkg::pcmT mPcm;
int mRun = 0;

function automatic sdPcmPkg::sampleT dropFraction(input longint p);
    return sdPcmPkg::sampleT'(p >>> sdPcmPkg::nMant);
endfunction

function automatic longint cmul(input sdPcmPkg::sampleT a, input sdPcmPkg::sampleT b);
    return longint'(a) * longint'(b);
endfunction

// A 1 adds the bit's factor, a 0 subtracts it
function automatic sdPcmPkg::cplxT windowSum(input logic [sampleWidth-1:0] win, input int s);
    int reAcc;
    int imAcc;
    sdPcmPkg::cplxT acc;
    reAcc = 0;
    imAcc = 0;
    for (int k = 0; k < sampleWidth; k++) begin
        reAcc += (win[k] ? 1 : -1) * int'(cFactor[s][k].re);
        imAcc += (win[k] ? 1 : -1) * int'(cFactor[s][k].im);
    end
    acc.re = sdPcmPkg::sampleT'(reAcc);
    acc.im = sdPcmPkg::sampleT'(imAcc);
    return acc;
endfunction

function automatic sdPcmPkg::pcmT combinePcm();
    int total;
    int level;
    total = 0;
    for (int s = 0; s < numSections; s++) begin
        total += int'(mPart[s]);
    end
    // Wrap to the internal width before rescaling
    level = int'(sdPcmPkg::sampleT'(total)) >>> (sdPcmPkg::nMant - sdPcmPkg::outWidth + 1);
    if (level > pcmMax) begin
        level = pcmMax;
    end else if (level < -pcmMax - 1) begin
        level = -pcmMax - 1;
    end
    return sdPcmPkg::pcmT'(level + pcmMax + 1);
endfunction

function automatic logic modelValid();
    return mRun >= depth + 4;
endfunction

task automatic stepModel(input logic rstIn, input logic [sampleWidth-1:0] win);
    logic [sampleWidth-1:0] oldWord;
    sdPcmPkg::cplxT x;
    longint pRe;
    longint pIm;
    oldWord = mLine[depth-1];
    for (int i = depth - 1; i > 0; i--) begin
        mLine[i] = mLine[i-1];
    end
    mLine[0] = win;
    if (!rstIn) begin
        mRun = 0;
        mPcm = sdPcmPkg::pcmT'(pcmMax + 1);
        for (int s = 0; s < numSections; s++) begin
            mLutNew[s] = '0;
            mLutOld[s] = '0;
            mY[s] = '0;
            mPart[s] = '0;
        end
    end else begin
        mRun++;
        // Later stages first, so each one reads last cycle's values
        mPcm = combinePcm();
        for (int s = 0; s < numSections; s++) begin
            mPart[s] = dropFraction(cmul(cWeight[s].re, mY[s].re)
                                    - cmul(cWeight[s].im, mY[s].im));
            x = mLutNew[s];
            // Old window counts once it holds a word from after reset
            if (mRun - 2 >= depth) begin
                x.re = x.re - mLutOld[s].re;
                x.im = x.im - mLutOld[s].im;
            end
            pRe = cmul(cFeedback[s].re, mY[s].re) - cmul(cFeedback[s].im, mY[s].im);
            pIm = cmul(cFeedback[s].re, mY[s].im) + cmul(cFeedback[s].im, mY[s].re);
            mY[s].re = x.re + dropFraction(pRe);
            mY[s].im = x.im + dropFraction(pIm);
            mLutNew[s] = windowSum(win, s);
            mLutOld[s] = windowSum(oldWord, s);
        end
    end
endtask

`endif

/* sim/sdPcmConverterTb.sv */
`timescale 1ns/1ns

module sdPcmConverterTb;

    localparam int sampleWidth = 8;
    localparam int depth = 16;
    localparam int numSections = 3;
    localparam int resetCycles = 3;
    localparam int coefWrites = numSections * (2 * sampleWidth + 4);
    localparam int rowMargin = 50;
    localparam int numRows = 7;
    localparam sdPcmPkg::pcmT offsetZero = 14'h2000;
    localparam sdPcmPkg::sampleT unity = sdPcmPkg::sampleT'(1 << sdPcmPkg::nMant);

    typedef enum logic [1:0] {zeroFb, cplxFb, largeFactor} coefStyleT;
    typedef enum logic [1:0] {allOnes, alternating, randomBits} patternT;

    typedef struct packed {
        coefStyleT style;
        patternT pattern;
        logic [7:0] cycles;
        logic midReset;
        logic mustSaturate;
    } caseRowT;

    logic clkDS = 1'b0;
    logic rst;
    logic [sampleWidth-1:0] bits;
    sdPcmPkg::coefWriteT coefWrite;
    sdPcmPkg::pcmT pcm;
    logic pcmValid;

    caseRowT caseTable [numRows];
    logic [sampleWidth-1:0] bitLog [256];
    sdPcmPkg::pcmT pcmLog [256];
    int cycleCount = 0;
    int cycleLimit = 0;
    int seedInit;

    `include "sdPcmRefModel.svh"

    sdPcmConverter #(
        .sampleWidth(sampleWidth),
        .depth(depth),
        .numSections(numSections)
    ) u_sdPcmConverter (
        .clkDS(clkDS),
        .rst(rst),
        .bits(bits),
        .coefWrite(coefWrite),
        .pcm(pcm),
        .pcmValid(pcmValid)
    );

    always #2 clkDS = ~clkDS;

    always @(posedge clkDS) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            stopWithFailure();
        end
    end

    task automatic stopWithFailure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkPcm(input sdPcmPkg::pcmT expected, input sdPcmPkg::pcmT actual);
        if (actual !== expected) begin
            $display("[FAIL] pcm expected %h actual %h at cycle %0d", expected, actual, cycleCount);
            stopWithFailure();
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] pcmValid expected %h actual %h at cycle %0d",
                     expected, actual, cycleCount);
            stopWithFailure();
        end
    endtask

    // Outputs have settled 1 ns after the edge, before inputs change
    task automatic tick();
        @(posedge clkDS);
        stepModel(rst, bits);
        #1;
        checkValid(modelValid(), pcmValid);
        checkPcm(mPcm, pcm);
    endtask

    function automatic sdPcmPkg::sampleT randSigned(input int span);
        return sdPcmPkg::sampleT'(int'($urandom % (2 * span)) - span);
    endfunction

    function automatic logic [sampleWidth-1:0] nextBits(input patternT pattern, input int i);
        case (pattern)
            allOnes: return '1;
            alternating: return (i % 2 == 0) ? {(sampleWidth/2){2'b10}} : {(sampleWidth/2){2'b01}};
            default: return sampleWidth'($urandom);
        endcase
    endfunction

    task automatic setCoefs(input coefStyleT style);
        logic active;
        for (int s = 0; s < numSections; s++) begin
            // Zero-feedback style drives section 0 only
            active = (style != zeroFb) || (s == 0);
            for (int k = 0; k < sampleWidth; k++) begin
                case (style)
                    zeroFb: cFactor[s][k].re = randSigned(512);
                    cplxFb: cFactor[s][k].re = randSigned(128);
                    default: cFactor[s][k].re = sdPcmPkg::sampleT'(4000 + int'($urandom % 2000));
                endcase
                cFactor[s][k].im = randSigned(style == cplxFb ? 128 : 512);
                if (!active) begin
                    cFactor[s][k] = '0;
                end
            end
            cFeedback[s] = '0;
            cWeight[s] = '0;
            if (style == cplxFb) begin
                cFeedback[s].re = sdPcmPkg::sampleT'(11000 - 2000 * s);
                cFeedback[s].im = sdPcmPkg::sampleT'((s % 2 == 0) ? 6000 : -6000);
                cWeight[s].re = unity >>> 2;
                cWeight[s].im = sdPcmPkg::sampleT'(2048 * (s + 1));
            end else if (active) begin
                cWeight[s].re = unity;
                cWeight[s].im = (style == zeroFb) ? unity >>> 1 : '0;
            end
        end
    endtask

    task automatic writeCoef(input sdPcmPkg::coefFieldT field, input int s, input int k,
                             input sdPcmPkg::sampleT value);
        coefWrite.en = 1'b1;
        coefWrite.field = field;
        coefWrite.section = 4'(s);
        coefWrite.index = 6'(k);
        coefWrite.value = value;
        tick();
    endtask

    task automatic loadCoefs();
        for (int s = 0; s < numSections; s++) begin
            for (int k = 0; k < sampleWidth; k++) begin
                writeCoef(sdPcmPkg::lutFactorRe, s, k, cFactor[s][k].re);
                writeCoef(sdPcmPkg::lutFactorIm, s, k, cFactor[s][k].im);
            end
            writeCoef(sdPcmPkg::feedbackRe, s, 0, cFeedback[s].re);
            writeCoef(sdPcmPkg::feedbackIm, s, 0, cFeedback[s].im);
            writeCoef(sdPcmPkg::weightRe, s, 0, cWeight[s].re);
            writeCoef(sdPcmPkg::weightIm, s, 0, cWeight[s].im);
        end
        coefWrite = '0;
    endtask

    task automatic holdReset();
        rst = 1'b0;
        bits = '0;
        for (int i = 0; i < resetCycles; i++) begin
            tick();
            checkValid(1'b0, pcmValid);
            checkPcm(offsetZero, pcm);
        end
    endtask

    task automatic runRow(input int r);
        caseRowT row;
        int satCount;
        row = caseTable[r];
        satCount = 0;
        setCoefs(row.style);
        holdReset();
        loadCoefs();
        rst = 1'b1;
        for (int i = 0; i < int'(row.cycles); i++) begin
            bits = nextBits(row.pattern, i);
            bitLog[i] = bits;
            tick();
            pcmLog[i] = mPcm;
            if (pcm == '0 || pcm == '1) begin
                satCount++;
            end
        end
        // Same coefficients, same words, so the output must repeat
        if (row.midReset) begin
            holdReset();
            rst = 1'b1;
            for (int i = 0; i < int'(row.cycles); i++) begin
                bits = bitLog[i];
                tick();
                checkPcm(pcmLog[i], pcm);
            end
        end
        if (row.mustSaturate && satCount == 0) begin
            $display("Row %0d never drove pcm to a saturation limit", r);
            stopWithFailure();
        end
    endtask

    function automatic int computeLimit();
        int total;
        total = 0;
        for (int r = 0; r < numRows; r++) begin
            total += resetCycles + coefWrites + int'(caseTable[r].cycles) + rowMargin;
            if (caseTable[r].midReset) begin
                total += resetCycles + int'(caseTable[r].cycles);
            end
        end
        return total;
    endfunction

    initial begin
        rst = 1'b0;
        bits = '0;
        coefWrite = '0;
        seedInit = $urandom(32'h549d);
        caseTable[0] = '{zeroFb, allOnes, 8'd40, 1'b0, 1'b0};
        caseTable[1] = '{zeroFb, alternating, 8'd40, 1'b0, 1'b0};
        caseTable[2] = '{zeroFb, randomBits, 8'd80, 1'b0, 1'b0};
        caseTable[3] = '{cplxFb, randomBits, 8'd150, 1'b0, 1'b0};
        caseTable[4] = '{cplxFb, randomBits, 8'd100, 1'b1, 1'b0};
        caseTable[5] = '{largeFactor, randomBits, 8'd60, 1'b0, 1'b1};
        caseTable[6] = '{largeFactor, allOnes, 8'd40, 1'b1, 1'b1};
        cycleLimit = computeLimit();
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* logic/sdPcmConverter.sv */
`timescale 1ns/1ns

module sdPcmConverter #(
    parameter int sampleWidth = 8,
    parameter int depth = 16,
    parameter int numSections = 3
) (
    input  logic                   clkDS,
    input  logic                   rst,
    input  logic [sampleWidth-1:0] bits,
    input  sdPcmPkg::coefWriteT    coefWrite,
    output sdPcmPkg::pcmT          pcm,
    output logic                   pcmValid
);

    sdPcmPkg::cplxT lutFactor [numSections][sampleWidth];
    sdPcmPkg::cplxT feedback [numSections];
    sdPcmPkg::cplxT weight [numSections];
    sdPcmPkg::sampleT partReal [numSections];
    logic [sampleWidth-1:0] newWin;
    logic [sampleWidth-1:0] oldWin;
    logic oldValid;

    coefRegBank #(
        .sampleWidth(sampleWidth),
        .numSections(numSections)
    ) u_coefRegBank (
        .clkDS(clkDS),
        .coefWrite(coefWrite),
        .lutFactor(lutFactor),
        .feedback(feedback),
        .weight(weight)
    );

    windowDelay #(
        .sampleWidth(sampleWidth),
        .depth(depth)
    ) u_windowDelay (
        .clkDS(clkDS),
        .rst(rst),
        .bits(bits),
        .newWin(newWin),
        .oldWin(oldWin),
        .oldValid(oldValid),
        .pcmValid(pcmValid)
    );

    // One section per filter pole pair
    for (genvar s = 0; s < numSections; s++) begin : gSection
        filterSection #(
            .sampleWidth(sampleWidth)
        ) u_filterSection (
            .clkDS(clkDS),
            .rst(rst),
            .newWin(newWin),
            .oldWin(oldWin),
            .oldValid(oldValid),
            .lutFactor(lutFactor[s]),
            .feedback(feedback[s]),
            .weight(weight[s]),
            .partReal(partReal[s])
        );
    end

    sectionCombiner #(
        .numSections(numSections)
    ) u_sectionCombiner (
        .clkDS(clkDS),
        .rst(rst),
        .partReal(partReal),
        .pcm(pcm)
    );

endmodule

/* logic/sectionCombiner.sv */
`timescale 1ns/1ns

module sectionCombiner #(
    parameter int numSections = 3
) (
    input  logic             clkDS,
    input  logic             rst,
    input  sdPcmPkg::sampleT partReal [numSections],
    output sdPcmPkg::pcmT    pcm
);

    localparam int shift = sdPcmPkg::nMant - (sdPcmPkg::outWidth - 1);
    localparam sdPcmPkg::sampleT satHigh =
        sdPcmPkg::sampleT'((1 <<< (sdPcmPkg::outWidth - 1)) - 1);
    localparam sdPcmPkg::sampleT satLow = -satHigh - 1;
    // Offset-binary zero, only the top bit set
    localparam sdPcmPkg::pcmT pcmZero = sdPcmPkg::pcmT'(1) << (sdPcmPkg::outWidth - 1);

    sdPcmPkg::sampleT sum;
    sdPcmPkg::sampleT scaled;
    logic signed [sdPcmPkg::outWidth-1:0] sat;

    always_comb begin
        sum = '0;
        for (int s = 0; s < numSections; s++) begin
            sum = sum + partReal[s];
        end
        scaled = sum >>> shift;
        if (scaled > satHigh) begin
            sat = satHigh[sdPcmPkg::outWidth-1:0];
        end else if (scaled < satLow) begin
            sat = satLow[sdPcmPkg::outWidth-1:0];
        end else begin
            sat = scaled[sdPcmPkg::outWidth-1:0];
        end
    end

    // Two's complement to offset binary
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            pcm <= pcmZero;
        end else begin
            pcm <= {~sat[sdPcmPkg::outWidth-1], sat[sdPcmPkg::outWidth-2:0]};
        end
    end

endmodule

/* section/filterSection.sv */
`timescale 1ns/1ns

module filterSection #(
    parameter int sampleWidth = 8
) (
    input  logic                   clkDS,
    input  logic                   rst,
    input  logic [sampleWidth-1:0] newWin,
    input  logic [sampleWidth-1:0] oldWin,
    input  logic                   oldValid,
    input  sdPcmPkg::cplxT         lutFactor [sampleWidth],
    input  sdPcmPkg::cplxT         feedback,
    input  sdPcmPkg::cplxT         weight,
    output sdPcmPkg::sampleT       partReal
);

    sdPcmPkg::cplxT lutNew;
    sdPcmPkg::cplxT lutOld;
    sdPcmPkg::cplxT oldTerm;
    sdPcmPkg::cplxT diff;
    sdPcmPkg::cplxT recState;
    sdPcmPkg::productT weightedRe;
    logic oldValidD;

    bitWindowLut #(
        .sampleWidth(sampleWidth)
    ) u_lutNew (
        .clkDS(clkDS),
        .rst(rst),
        .win(newWin),
        .factor(lutFactor),
        .result(lutNew)
    );

    bitWindowLut #(
        .sampleWidth(sampleWidth)
    ) u_lutOld (
        .clkDS(clkDS),
        .rst(rst),
        .win(oldWin),
        .factor(lutFactor),
        .result(lutOld)
    );

    // Lines up with the registered LUT output
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            oldValidD <= 1'b0;
        end else begin
            oldValidD <= oldValid;
        end
    end

    always_comb begin
        oldTerm = oldValidD ? lutOld : '0;
        diff.re = lutNew.re - oldTerm.re;
        diff.im = lutNew.im - oldTerm.im;
    end

    cplxRecursion u_recursion (
        .clkDS(clkDS),
        .rst(rst),
        .x(diff),
        .a(feedback),
        .y(recState)
    );

    // Real part of weight * y
    assign weightedRe = sdPcmPkg::mul(weight.re, recState.re)
                      - sdPcmPkg::mul(weight.im, recState.im);

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            partReal <= '0;
        end else begin
            partReal <= sdPcmPkg::rescale(weightedRe);
        end
    end

endmodule

/* logic/cplxRecursion.sv */
`timescale 1ns/1ns

module cplxRecursion (
    input  logic           clkDS,
    input  logic           rst,
    input  sdPcmPkg::cplxT x,
    input  sdPcmPkg::cplxT a,
    output sdPcmPkg::cplxT y
);

    sdPcmPkg::productT prodRe;
    sdPcmPkg::productT prodIm;
    sdPcmPkg::cplxT yNext;

    // y_next = x + (a * y) >>> nMant
    always_comb begin
        prodRe = sdPcmPkg::mul(a.re, y.re) - sdPcmPkg::mul(a.im, y.im);
        prodIm = sdPcmPkg::mul(a.re, y.im) + sdPcmPkg::mul(a.im, y.re);
        yNext.re = x.re + sdPcmPkg::rescale(prodRe);
        yNext.im = x.im + sdPcmPkg::rescale(prodIm);
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            y <= '0;
        end else begin
            y <= yNext;
        end
    end

endmodule

/* logic/bitWindowLut.sv */
`timescale 1ns/1ns

module bitWindowLut #(
    parameter int sampleWidth = 8
) (
    input  logic                   clkDS,
    input  logic                   rst,
    input  logic [sampleWidth-1:0] win,
    input  sdPcmPkg::cplxT         factor [sampleWidth],
    output sdPcmPkg::cplxT         result
);

    sdPcmPkg::cplxT sum;

    // Bit 1 counts as +1, bit 0 as -1
    always_comb begin
        sum = '0;
        for (int k = 0; k < sampleWidth; k++) begin
            if (win[k]) begin
                sum.re = sum.re + factor[k].re;
                sum.im = sum.im + factor[k].im;
            end else begin
                sum.re = sum.re - factor[k].re;
                sum.im = sum.im - factor[k].im;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            result <= '0;
        end else begin
            result <= sum;
        end
    end

endmodule

/* logic/windowDelay.sv */
`timescale 1ns/1ns

module windowDelay #(
    parameter int sampleWidth = 8,
    parameter int depth = 16
) (
    input  logic                   clkDS,
    input  logic                   rst,
    input  logic [sampleWidth-1:0] bits,
    output logic [sampleWidth-1:0] newWin,
    output logic [sampleWidth-1:0] oldWin,
    output logic                   oldValid,
    output logic                   pcmValid
);

    localparam int countBits = $clog2(depth + 1);
    // LUT, recursion, weighting and combiner registers
    localparam int pipeStages = 4;

    logic [sampleWidth-1:0] winLine [depth];
    logic [countBits-1:0] fillCount;
    logic [pipeStages-1:0] validPipe;

    always_ff @(posedge clkDS) begin
        winLine[0] <= bits;
        for (int i = 1; i < depth; i++) begin
            winLine[i] <= winLine[i-1];
        end
    end

    // Saturates at depth, so oldValid stays up until reset
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fillCount <= '0;
            validPipe <= '0;
        end else begin
            if (fillCount != countBits'(depth)) begin
                fillCount <= fillCount + 1'b1;
            end
            validPipe <= {validPipe[pipeStages-2:0], oldValid};
        end
    end

    assign newWin = bits;
    assign oldWin = winLine[depth-1];
    assign oldValid = fillCount == countBits'(depth);
    assign pcmValid = validPipe[pipeStages-1];

endmodule

/* coef/coefRegBank.sv */
`timescale 1ns/1ns

module coefRegBank #(
    parameter int sampleWidth = 8,
    parameter int numSections = 3
) (
    input  logic                clkDS,
    input  sdPcmPkg::coefWriteT coefWrite,
    output sdPcmPkg::cplxT      lutFactor [numSections][sampleWidth],
    output sdPcmPkg::cplxT      feedback [numSections],
    output sdPcmPkg::cplxT      weight [numSections]
);

    logic secHit [numSections];
    logic idxHit [sampleWidth];

    // Address decode, out-of-range writes hit nothing
    always_comb begin
        for (int s = 0; s < numSections; s++) begin
            secHit[s] = coefWrite.en && (int'(coefWrite.section) == s);
        end
        for (int k = 0; k < sampleWidth; k++) begin
            idxHit[k] = int'(coefWrite.index) == k;
        end
    end

    // Coefficients survive a datapath reset
    always_ff @(posedge clkDS) begin
        for (int s = 0; s < numSections; s++) begin
            if (secHit[s]) begin
                case (coefWrite.field)
                    sdPcmPkg::lutFactorRe: begin
                        for (int k = 0; k < sampleWidth; k++) begin
                            if (idxHit[k]) begin
                                lutFactor[s][k].re <= coefWrite.value;
                            end
                        end
                    end
                    sdPcmPkg::lutFactorIm: begin
                        for (int k = 0; k < sampleWidth; k++) begin
                            if (idxHit[k]) begin
                                lutFactor[s][k].im <= coefWrite.value;
                            end
                        end
                    end
                    sdPcmPkg::feedbackRe: feedback[s].re <= coefWrite.value;
                    sdPcmPkg::feedbackIm: feedback[s].im <= coefWrite.value;
                    sdPcmPkg::weightRe:   weight[s].re <= coefWrite.value;
                    sdPcmPkg::weightIm:   weight[s].im <= coefWrite.value;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* common/sdPcmPkg.sv */
package sdPcmPkg;

    // Internal fixed-point format, sign + integer + fraction
    localparam int nInt = 9;
    localparam int nMant = 14;
    localparam int sampleBits = nInt + nMant + 1;

    // PCM output word
    localparam int outWidth = 14;

    // Field sizing for the coefficient write port
    localparam int maxSections = 16;
    localparam int maxWindow = 64;

    typedef logic signed [sampleBits-1:0] sampleT;

    // Full product of two internal values, one guard bit for sums of two
    typedef logic signed [2*sampleBits:0] productT;

    typedef struct packed {
        sampleT re;
        sampleT im;
    } cplxT;

    typedef logic [outWidth-1:0] pcmT;

    typedef enum logic [2:0] {
        lutFactorRe,
        lutFactorIm,
        feedbackRe,
        feedbackIm,
        weightRe,
        weightIm
    } coefFieldT;

    typedef struct packed {
        logic en;
        coefFieldT field;
        logic [$clog2(maxSections)-1:0] section;
        // Only meaningful for the LUT factor fields
        logic [$clog2(maxWindow)-1:0] index;
        sampleT value;
    } coefWriteT;

    // Signed product at full width
    function automatic productT mul(input sampleT a, input sampleT b);
        productT wideA;
        productT wideB;
        wideA = a;
        wideB = b;
        return wideA * wideB;
    endfunction

    // Back to the internal format, fraction bits dropped, top bits wrapped
    function automatic sampleT rescale(input productT p);
        productT shifted;
        shifted = p >>> nMant;
        return shifted[sampleBits-1:0];
    endfunction

endpackage
